/* source/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

    // Data path width
    localparam int DATA_WIDTH  = 8;

    // RAM address width, depth follows from it
    localparam int PTR_WIDTH   = 4;
    localparam int COUNT_WIDTH = PTR_WIDTH + 1;    // One extra bit to hold a full count
    localparam int FIFO_DEPTH  = 2 ** PTR_WIDTH;

    // Extra RAM output register at the top level
    localparam bit DOUT_REGS   = 1'b1;

    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [PTR_WIDTH-1:0]   ptr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

/* source/fifo_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port memory, registered read
module fifo_ram #(
    parameter bit DOUT_REGS = 1'b1
) (
    input  wire             clk,
    input  wire             cke,
    input  wire             wr_en,
    input  wire  fifo_pkg::ptr_t  wr_addr,
    input  wire  fifo_pkg::data_t wr_data,
    input  wire             rd_en,
    input  wire             rd_regcke,
    input  wire  fifo_pkg::ptr_t  rd_addr,
    output fifo_pkg::data_t rd_data
);
    import fifo_pkg::*;

    data_t mem [FIFO_DEPTH];
    data_t rd_reg;             // First read register

    always_ff @(posedge clk) begin
        if (cke && wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (cke && rd_en) begin
            rd_reg <= mem[rd_addr];
        end
    end

    generate
        if (DOUT_REGS) begin : g_out_reg
            data_t out_reg;

            // Second stage, advanced by the read pipeline
            always_ff @(posedge clk) begin
                if (cke && rd_regcke) begin
                    out_reg <= rd_reg;
                end
            end

            assign rd_data = out_reg;
        end else begin : g_no_out_reg
            assign rd_data = rd_reg;
        end
    endgenerate

endmodule

`default_nettype wire

/* source/fifo_ptr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Pointers, flags and stored-word count
module fifo_ptr_ctrl (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              cke,
    input  wire              s_valid,
    output logic             s_ready,
    output logic             wr_en,
    output fifo_pkg::ptr_t   wr_addr,
    input  wire              rd_en,
    output fifo_pkg::ptr_t   rd_addr,
    output logic             rd_empty,
    output fifo_pkg::count_t rd_count
);
    import fifo_pkg::*;

    // Pointers carry one wrap bit above the address
    count_t wr_ptr;
    count_t rd_ptr;
    count_t wr_ptr_next;
    count_t rd_ptr_next;
    logic   full;

    assign s_ready = !full;
    assign wr_en   = cke && s_valid && !full;

    assign wr_addr = wr_ptr[PTR_WIDTH-1:0];
    assign rd_addr = rd_ptr[PTR_WIDTH-1:0];

    assign wr_ptr_next = wr_ptr + count_t'(wr_en);
    assign rd_ptr_next = rd_ptr + count_t'(rd_en);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            full     <= 1'b0;
            rd_empty <= 1'b1;
            rd_count <= '0;
        end else if (cke) begin
            wr_ptr   <= wr_ptr_next;
            rd_ptr   <= rd_ptr_next;

            // Flags from the next pointers, so they stay registered
            rd_empty <= (wr_ptr_next == rd_ptr_next);
            full     <= ((wr_ptr_next - rd_ptr_next) == count_t'(FIFO_DEPTH));

            case ({wr_en, rd_en})
                2'b10:   rd_count <= rd_count + 1'b1;
                2'b01:   rd_count <= rd_count - 1'b1;
                default: rd_count <= rd_count;    // Both or neither
            endcase
        end
    end

    // Read side pops only what the flags report as present
    no_read_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |-> !rd_empty
    );

    count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_count <= count_t'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

/* source/fifo_pipeline_control.sv */
`timescale 1ns/1ps
`default_nettype none

// Valid tracking and stage enables for the RAM read path,
// skid buffer and output register on the far end
module fifo_pipeline_control #(
    parameter int PIPELINE_STAGES = 2
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cke,
    input  wire                        s_valid,
    output logic [PIPELINE_STAGES-1:0] stage_cke,
    output logic [PIPELINE_STAGES-1:0] stage_valid,
    input  wire  fifo_pkg::data_t      sink_data,
    output fifo_pkg::data_t            m_data,
    output logic                       m_valid,
    input  wire                        m_ready,
    output logic                       buffered
);
    import fifo_pkg::*;

    typedef enum logic [1:0] {
        state_empty,
        state_full,
        state_buffered
    } out_state_t;

    out_state_t                 state;
    data_t                      buf_data;     // Skid buffer word
    logic [PIPELINE_STAGES-1:0] stage_move;   // Stage content leaves this edge
    logic                       sink_ready;
    logic                       sink_valid;

    // Registered only, m_ready stays out of the stage enables
    assign sink_ready = (state != state_buffered);
    assign sink_valid = stage_move[PIPELINE_STAGES-1];

    always_comb begin
        stage_move[PIPELINE_STAGES-1] = stage_valid[PIPELINE_STAGES-1] && sink_ready;
        for (int k = PIPELINE_STAGES - 2; k >= 0; k--) begin
            // Hold while the stage ahead is occupied and stuck
            stage_move[k] = stage_valid[k] && (!stage_valid[k+1] || stage_move[k+1]);
        end
    end

    always_comb begin
        stage_cke[0] = cke && s_valid && (!stage_valid[0] || stage_move[0]);
        for (int k = 1; k < PIPELINE_STAGES; k++) begin
            stage_cke[k] = cke && stage_move[k-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (cke) begin
            for (int k = 0; k < PIPELINE_STAGES; k++) begin
                if (stage_cke[k]) begin
                    stage_valid[k] <= 1'b1;
                end else if (stage_move[k]) begin
                    stage_valid[k] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= state_empty;
        end else if (cke) begin
            case (state)
                state_empty: begin
                    if (sink_valid) state <= state_full;
                end
                state_full: begin
                    if (sink_valid && !m_ready) begin
                        state <= state_buffered;    // Late word goes to the skid buffer
                    end else if (!sink_valid && m_ready) begin
                        state <= state_empty;
                    end
                end
                state_buffered: begin
                    if (m_ready) state <= state_full;
                end
                default: state <= state_empty;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            case (state)
                state_empty: begin
                    if (sink_valid) m_data <= sink_data;
                end
                state_full: begin
                    if (sink_valid && m_ready) begin
                        m_data <= sink_data;
                    end else if (sink_valid) begin
                        buf_data <= sink_data;
                    end
                end
                state_buffered: begin
                    if (m_ready) m_data <= buf_data;    // Refill from the skid buffer
                end
                default: ;
            endcase
        end
    end

    assign m_valid  = (state != state_empty);
    assign buffered = (state == state_buffered);

    // Stalled output keeps its word
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data)
    );

endmodule

`default_nettype wire

/* source/fifo_read_fwft.sv */
`timescale 1ns/1ps
`default_nettype none

// First-word fall-through read side
module fifo_read_fwft #(
    parameter bit DOUT_REGS = 1'b1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              cke,
    output logic             rd_en,
    output logic             rd_regcke,
    input  wire  fifo_pkg::data_t  rd_data,
    input  wire              rd_empty,
    input  wire  fifo_pkg::count_t rd_count,
    output fifo_pkg::data_t  m_data,
    output logic             m_valid,
    input  wire              m_ready,
    output fifo_pkg::count_t m_count
);
    import fifo_pkg::*;

    localparam int PIPELINE_STAGES = 1 + int'(DOUT_REGS);

    logic [PIPELINE_STAGES-1:0] stage_cke;
    logic [PIPELINE_STAGES-1:0] stage_valid;
    logic                       buffered;

    fifo_pipeline_control #(
        .PIPELINE_STAGES (PIPELINE_STAGES)
    ) pipeline_control_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cke         (cke),
        .s_valid     (!rd_empty),
        .stage_cke   (stage_cke),
        .stage_valid (stage_valid),
        .sink_data   (rd_data),
        .m_data      (m_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .buffered    (buffered)
    );

    assign rd_en = stage_cke[0];    // Pop and RAM read on the same edge

    generate
        if (DOUT_REGS) begin : g_dout_reg
            assign rd_regcke = stage_cke[1];
        end else begin : g_no_dout_reg
            assign rd_regcke = 1'b0;
        end
    endgenerate

    // Words still in RAM plus everything in flight
    always_comb begin
        m_count = rd_count + count_t'(m_valid) + count_t'(buffered);
        for (int k = 0; k < PIPELINE_STAGES; k++) begin
            m_count = m_count + count_t'(stage_valid[k]);
        end
    end

endmodule

`default_nettype wire

/* source/fifo_fwft.sv */
`timescale 1ns/1ps
`default_nettype none

// Synchronous FIFO with first-word fall-through read port
module fifo_fwft (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              cke,
    input  wire  fifo_pkg::data_t s_data,
    input  wire              s_valid,
    output logic             s_ready,
    output fifo_pkg::data_t  m_data,
    output logic             m_valid,
    input  wire              m_ready,
    output fifo_pkg::count_t m_count
);
    import fifo_pkg::*;

    logic   wr_en;
    ptr_t   wr_addr;
    ptr_t   rd_addr;
    logic   rd_en;
    logic   rd_regcke;
    data_t  rd_data;
    logic   rd_empty;
    count_t rd_count;

    fifo_ram #(
        .DOUT_REGS (DOUT_REGS)
    ) fifo_ram_i (
        .clk       (clk),
        .cke       (cke),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (s_data),    // Write data straight from the port
        .rd_en     (rd_en),
        .rd_regcke (rd_regcke),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    fifo_ptr_ctrl fifo_ptr_ctrl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cke      (cke),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_empty (rd_empty),
        .rd_count (rd_count)
    );

    fifo_read_fwft #(
        .DOUT_REGS (DOUT_REGS)
    ) fifo_read_fwft_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cke       (cke),
        .rd_en     (rd_en),
        .rd_regcke (rd_regcke),
        .rd_data   (rd_data),
        .rd_empty  (rd_empty),
        .rd_count  (rd_count),
        .m_data    (m_data),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_count   (m_count)
    );

endmodule

`default_nettype wire

/* verification/tb_fifo_fwft.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_fwft;
    import fifo_pkg::*;

    localparam int          CLK_PERIOD      = 20;
    localparam int          DRIVE_DELAY     = 2;
    localparam int          RESET_CYCLES    = 5;
    localparam int          WATCHDOG_MARGIN = 200;
    localparam logic [31:0] SEED            = 32'h9ef6fe05;
    // Read stage, RAM output register, output register and skid buffer
    localparam int          PIPE_WORDS      = 3 + int'(DOUT_REGS);

    logic   clk = 1'b0;
    logic   rst_n;
    logic   cke;
    data_t  s_data;
    logic   s_valid;
    logic   s_ready;
    data_t  m_data;
    logic   m_valid;
    logic   m_ready;
    count_t m_count;

    // Stimulus table, one entry per phase
    string row_name[$];
    int    row_cycles[$];
    int    row_wr_pct[$];
    int    row_rd_pct[$];
    logic  row_cke[$];

    data_t       model_q[$];    // Accepted, not yet delivered
    logic [31:0] rng_state;
    logic        prev_stall;    // Output held over the last edge
    data_t       prev_data;

    fifo_fwft fifo_fwft_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_data  (s_data),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (m_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_count (m_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_row(input string name, input int cycles, input int wr_pct,
                           input int rd_pct, input logic row_cke_value);
        row_name.push_back(name);
        row_cycles.push_back(cycles);
        row_wr_pct.push_back(wr_pct);
        row_rd_pct.push_back(rd_pct);
        row_cke.push_back(row_cke_value);
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic roll_percent(input int pct, output logic hit);
        rng_state = lcg_step(rng_state);
        hit = (int'(rng_state[31:16]) % 100) < pct;    // Upper bits are the better ones
    endtask

    task automatic end_with_failure(input string reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                     test, what, expected, actual);
            end_with_failure({"wrong value of ", what, " in ", test});
        end
    endtask

    // Sampled mid-cycle, transfers belong to the coming edge
    task automatic check_and_update(input string test);
        if (prev_stall) begin
            check_value(test, "m_valid held", 32'd1, 32'(m_valid));
            check_value(test, "m_data held", 32'(prev_data), 32'(m_data));
        end
        check_value(test, "m_count", 32'(model_q.size()), 32'(m_count));
        if (cke && m_valid && m_ready) begin
            assert (model_q.size() > 0) else begin
                end_with_failure({"a word was delivered with none written in ", test});
            end
            check_value(test, "m_data", 32'(model_q[0]), 32'(m_data));
            void'(model_q.pop_front());
        end
        if (cke && s_valid && s_ready) begin
            model_q.push_back(s_data);
        end
        prev_stall = m_valid && !(cke && m_ready);
        prev_data  = m_data;
    endtask

    task automatic check_row_end(input int idx);
        string test;

        test = row_name[idx];
        if (row_cke[idx] && row_wr_pct[idx] == 100 && row_rd_pct[idx] == 0) begin
            check_value(test, "s_ready when full", 32'd0, 32'(s_ready));
            check_value(test, "words held when full", 32'(FIFO_DEPTH + PIPE_WORDS),
                        32'(model_q.size()));
        end
        if (row_cke[idx] && row_wr_pct[idx] == 0 && row_rd_pct[idx] == 100) begin
            check_value(test, "words left after drain", 32'd0, 32'(model_q.size()));
            check_value(test, "m_valid after drain", 32'd0, 32'(m_valid));
        end
        if (row_cke[idx] && row_wr_pct[idx] == 0 && row_rd_pct[idx] == 0) begin
            check_value(test, "m_count after idle", 32'(model_q.size()), 32'(m_count));
        end
    endtask

    task automatic run_row(input int idx);
        string  test;
        logic   hit;
        count_t frozen_count;
        logic   frozen_valid;
        data_t  frozen_data;

        test = row_name[idx];
        for (int c = 0; c < row_cycles[idx]; c++) begin
            cke = row_cke[idx];
            rng_state = lcg_step(rng_state);
            s_data = rng_state[31 -: DATA_WIDTH];
            roll_percent(row_wr_pct[idx], hit);
            s_valid = hit;
            roll_percent(row_rd_pct[idx], hit);
            m_ready = hit;

            @(negedge clk);
            if (!row_cke[idx] && c == 0) begin
                frozen_count = m_count;    // State as the freeze begins
                frozen_valid = m_valid;
                frozen_data  = m_data;
            end else if (!row_cke[idx]) begin
                check_value(test, "frozen m_count", 32'(frozen_count), 32'(m_count));
                check_value(test, "frozen m_valid", 32'(frozen_valid), 32'(m_valid));
                if (frozen_valid) begin
                    check_value(test, "frozen m_data", 32'(frozen_data), 32'(m_data));
                end
            end
            check_and_update(test);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        check_row_end(idx);
    endtask

    initial begin
        rst_n      = 1'b0;
        cke        = 1'b1;
        s_data     = '0;
        s_valid    = 1'b0;
        m_ready    = 1'b0;
        rng_state  = SEED;
        prev_stall = 1'b0;
        prev_data  = '0;

        //       name            cycles  wr%  rd%  cke
        add_row("fill_random",       60,  70,  30, 1'b1);
        add_row("random_mix",       200,  50,  50, 1'b1);
        add_row("backpressure",      30,  80,   0, 1'b1);
        add_row("drain_bp",          40,   0, 100, 1'b1);
        add_row("fill_to_full",      30, 100,   0, 1'b1);
        add_row("idle_full",         10,   0,   0, 1'b1);
        add_row("cke_low_full",      20,  60,  60, 1'b0);
        add_row("drain_full",        40,   0, 100, 1'b1);
        add_row("random_fast",      200,  90,  90, 1'b1);
        add_row("cke_low_busy",      15,  50,  50, 1'b0);
        add_row("random_slow",      150,  30,  70, 1'b1);
        add_row("idle",              10,   0,   0, 1'b1);
        add_row("drain_final",       40,   0, 100, 1'b1);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        @(negedge clk);
        check_value("reset", "m_valid", 32'd0, 32'(m_valid));
        check_value("reset", "s_ready", 32'd1, 32'(s_ready));
        check_value("reset", "m_count", 32'd0, 32'(m_count));
        @(posedge clk);
        #DRIVE_DELAY;

        foreach (row_name[i]) begin
            run_row(i);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit_cycles;

        #1;
        limit_cycles = RESET_CYCLES + WATCHDOG_MARGIN;
        foreach (row_cycles[i]) begin
            limit_cycles += row_cycles[i];
        end
        #(limit_cycles * CLK_PERIOD);
        end_with_failure("the watchdog expired before all phases finished");
    end

endmodule

`default_nettype wire

/* flist.f */
source/fifo_pkg.sv
source/fifo_ram.sv
source/fifo_ptr_ctrl.sv
source/fifo_pipeline_control.sv
source/fifo_read_fwft.sv
source/fifo_fwft.sv
verification/tb_fifo_fwft.sv

/* Makefile */
# Verilator build and run for the FWFT FIFO testbench
VERILATOR ?= verilator
TOP       ?= tb_fifo_fwft
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
